// ==== verilog/mmio_pkg.sv ====
`default_nettype none

package mmio_pkg;

  //////////////////////////////////////////////////
  // Widths fixed by the host link
  //////////////////////////////////////////////////
  localparam int addr_w = 24;
  localparam int data_w = 64;

  // One host request per valid cycle
  typedef struct packed {
    logic              valid;
    logic              cfg;
    logic              read;
    logic              doubleword;
    logic [addr_w-1:0] address;
    logic              address_parity;
    logic [data_w-1:0] data;
    logic              data_parity;
  } mmio_req_t;

  typedef struct packed {
    logic              ack;
    logic [data_w-1:0] data;
    logic              data_parity;
  } mmio_resp_t;

  typedef enum logic [2:0] {
    op_none,
    op_cfg_read,
    op_cfg_write,
    op_mmio_read,
    op_mmio_write
  } mmio_op_e;

  // Classified request as it travels down the pipeline
  typedef struct packed {
    mmio_op_e          op;
    logic              doubleword;
    logic [addr_w-1:0] address;
    logic [data_w-1:0] data;
    logic              address_parity;
    logic              data_parity;
  } mmio_cmd_t;

  typedef struct packed {
    logic [data_w-1:0] var1;
    logic [data_w-1:0] var2;
  } cu_return_t;

  typedef struct packed {
    logic [data_w-1:0] var1;
    logic [data_w-1:0] var2;
    logic [data_w-1:0] var3;
    logic [data_w-1:0] var4;
  } cu_configure_t;

  typedef struct packed {
    logic [data_w-1:0] var1;
    logic [data_w-1:0] var2;
  } afu_configure_t;

  typedef struct packed {
    logic data_error;
    logic address_error;
  } mmio_errors_t;

  //////////////////////////////////////////////////
  // MMIO register map in word addresses
  //////////////////////////////////////////////////
  localparam logic [addr_w-1:0] reg_cu_configure_0      = 24'h00_0040;
  localparam logic [addr_w-1:0] reg_cu_configure_1      = 24'h00_0048;
  localparam logic [addr_w-1:0] reg_cu_configure_2      = 24'h00_0050;
  localparam logic [addr_w-1:0] reg_cu_configure_3      = 24'h00_0058;
  localparam logic [addr_w-1:0] reg_afu_configure_0     = 24'h00_0060;
  localparam logic [addr_w-1:0] reg_afu_configure_1     = 24'h00_0068;
  localparam logic [addr_w-1:0] reg_cu_return_done_ack  = 24'h00_0070;
  localparam logic [addr_w-1:0] reg_error_reg_ack       = 24'h00_0078;

  localparam logic [addr_w-1:0] reg_cu_return_0         = 24'h00_0080;
  localparam logic [addr_w-1:0] reg_cu_return_1         = 24'h00_0088;
  localparam logic [addr_w-1:0] reg_cu_return_done_0    = 24'h00_0090;
  localparam logic [addr_w-1:0] reg_cu_return_done_1    = 24'h00_0098;
  localparam logic [addr_w-1:0] reg_error_reg           = 24'h00_00a0;
  localparam logic [addr_w-1:0] reg_afu_status          = 24'h00_00a8;
  localparam logic [addr_w-1:0] reg_cu_status           = 24'h00_00b0;

  //////////////////////////////////////////////////
  // Accelerator descriptor doublewords
  //////////////////////////////////////////////////
  // Ints 0, processes 1, CR sets 1, dedicated process model
  localparam logic [data_w-1:0] desc_dw_0 = 64'h0000_0001_0001_8010;
  localparam logic [data_w-1:0] desc_dw_1 = 64'h0000_0000_0000_0000;
  localparam logic [data_w-1:0] desc_dw_2 = 64'h0000_0000_0000_0000;
  localparam logic [data_w-1:0] desc_dw_3 = 64'h0000_0000_0000_0000;
  localparam logic [data_w-1:0] desc_dw_4 = 64'h0000_0000_0000_0000;
  // CR length and CR offset
  localparam logic [data_w-1:0] desc_dw_5 = 64'h0000_0000_0000_0001;
  localparam logic [data_w-1:0] desc_dw_6 = 64'h0000_0000_0000_0100;
  // Problem-state area required
  localparam logic [data_w-1:0] desc_dw_7 = 64'h0100_0000_0000_0000;

  // Bit that makes the total count of ones odd
  function automatic logic odd_parity(input logic [data_w-1:0] value);
    return ~(^value);
  endfunction

endpackage

`default_nettype wire

// ==== verilog/mmio_request_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module mmio_request_decode (
  input  wire                 clock,
  input  wire                 rstn,
  input  mmio_pkg::mmio_req_t mmio_in,
  output mmio_pkg::mmio_cmd_t cmd
);

  mmio_pkg::mmio_req_t req_q;
  mmio_pkg::mmio_cmd_t cls_q;
  mmio_pkg::mmio_op_e  op_d;

  // Raw request straight off the link
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      req_q <= '0;
    end else begin
      req_q <= mmio_in;
    end
  end

  // Kind of access from the cfg and read bits
  always_comb begin
    op_d = mmio_pkg::op_none;
    if (req_q.valid) begin
      case ({req_q.cfg, req_q.read})
        2'b11:   op_d = mmio_pkg::op_cfg_read;
        2'b10:   op_d = mmio_pkg::op_cfg_write;
        2'b01:   op_d = mmio_pkg::op_mmio_read;
        default: op_d = mmio_pkg::op_mmio_write;
      endcase
    end
  end

  // Idle fields are zero with a parity bit that matches zero
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cls_q <= '0;
    end else begin
      cls_q.op             <= op_d;
      cls_q.address        <= req_q.valid ? req_q.address : '0;
      cls_q.address_parity <= req_q.valid ? req_q.address_parity : 1'b1;
      if (req_q.valid && !req_q.read) begin
        cls_q.data        <= req_q.data;
        cls_q.data_parity <= req_q.data_parity;
      end else begin
        cls_q.data        <= '0;
        cls_q.data_parity <= 1'b1;
      end
      // Width flag sticks from the last valid request
      if (req_q.valid) begin
        cls_q.doubleword <= req_q.doubleword;
      end
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cmd <= '0;
    end else begin
      cmd <= cls_q;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/afu_descriptor_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module afu_descriptor_rom (
  input  wire                               clock,
  input  wire                               rstn,
  input  mmio_pkg::mmio_cmd_t               cmd,
  output logic [mmio_pkg::data_w-1:0]       desc_data
);

  logic [mmio_pkg::addr_w-2:0] dw_index;
  logic [mmio_pkg::data_w-1:0] dw_lookup;

  // Word address to doubleword index
  assign dw_index = cmd.address[mmio_pkg::addr_w-1:1];

  always_comb begin
    case (dw_index)
      23'd0:   dw_lookup = mmio_pkg::desc_dw_0;
      23'd1:   dw_lookup = mmio_pkg::desc_dw_1;
      23'd2:   dw_lookup = mmio_pkg::desc_dw_2;
      23'd3:   dw_lookup = mmio_pkg::desc_dw_3;
      23'd4:   dw_lookup = mmio_pkg::desc_dw_4;
      23'd5:   dw_lookup = mmio_pkg::desc_dw_5;
      23'd6:   dw_lookup = mmio_pkg::desc_dw_6;
      23'd7:   dw_lookup = mmio_pkg::desc_dw_7;
      default: dw_lookup = '0;
    endcase
  end

  // Zero unless a config read is in this stage
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      desc_data <= '0;
    end else if (cmd.op == mmio_pkg::op_cfg_read) begin
      desc_data <= dw_lookup;
    end else begin
      desc_data <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mmio_write_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module mmio_write_regs (
  input  wire                      clock,
  input  wire                      rstn,
  input  mmio_pkg::mmio_cmd_t      cmd,
  output mmio_pkg::cu_configure_t  cu_configure,
  output mmio_pkg::afu_configure_t afu_configure,
  output logic                     cu_return_done_ack,
  output logic                     report_errors_ack
);

  mmio_pkg::mmio_cmd_t         cmd_q;
  mmio_pkg::cu_configure_t     cu_cfg_q;
  mmio_pkg::afu_configure_t    afu_cfg_q;
  logic [mmio_pkg::data_w-1:0] cu_ack_word;
  logic [mmio_pkg::data_w-1:0] err_ack_word;
  logic                        cu_ack_q;
  logic                        err_ack_q;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cmd_q <= '0;
    end else begin
      cmd_q <= cmd;
    end
  end

  //////////////////////////////////////////////////
  // Write decode into one-cycle register pulses
  //////////////////////////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cu_cfg_q     <= '0;
      afu_cfg_q    <= '0;
      cu_ack_word  <= '0;
      err_ack_word <= '0;
    end else begin
      cu_cfg_q     <= '0;
      afu_cfg_q    <= '0;
      cu_ack_word  <= '0;
      err_ack_word <= '0;
      if (cmd_q.op == mmio_pkg::op_mmio_write) begin
        case (cmd_q.address)
          mmio_pkg::reg_cu_configure_0:     cu_cfg_q.var1  <= cmd_q.data;
          mmio_pkg::reg_cu_configure_1:     cu_cfg_q.var2  <= cmd_q.data;
          mmio_pkg::reg_cu_configure_2:     cu_cfg_q.var3  <= cmd_q.data;
          mmio_pkg::reg_cu_configure_3:     cu_cfg_q.var4  <= cmd_q.data;
          mmio_pkg::reg_afu_configure_0:    afu_cfg_q.var1 <= cmd_q.data;
          mmio_pkg::reg_afu_configure_1:    afu_cfg_q.var2 <= cmd_q.data;
          mmio_pkg::reg_cu_return_done_ack: cu_ack_word    <= cmd_q.data;
          mmio_pkg::reg_error_reg_ack:      err_ack_word   <= cmd_q.data;
          default: ;
        endcase
      end
    end
  end

  // Any set bit acknowledges
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cu_ack_q  <= 1'b0;
      err_ack_q <= 1'b0;
    end else begin
      cu_ack_q  <= |cu_ack_word;
      err_ack_q <= |err_ack_word;
    end
  end

  // Output stage
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cu_configure       <= '0;
      afu_configure      <= '0;
      cu_return_done_ack <= 1'b0;
      report_errors_ack  <= 1'b0;
    end else begin
      cu_configure       <= cu_cfg_q;
      afu_configure      <= afu_cfg_q;
      cu_return_done_ack <= cu_ack_q;
      report_errors_ack  <= err_ack_q;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mmio_read_path.sv ====
`timescale 1ns/1ns
`default_nettype none

module mmio_read_path (
  input  wire                         clock,
  input  wire                         rstn,
  input  mmio_pkg::mmio_cmd_t         cmd,
  input  wire [mmio_pkg::data_w-1:0]  desc_data,
  input  mmio_pkg::cu_return_t        cu_return,
  input  mmio_pkg::cu_return_t        cu_return_done,
  input  wire [mmio_pkg::data_w-1:0]  report_errors,
  input  wire [mmio_pkg::data_w-1:0]  afu_status,
  input  wire [mmio_pkg::data_w-1:0]  cu_status,
  output mmio_pkg::mmio_resp_t        mmio_out
);

  mmio_pkg::cu_return_t        cu_return_q;
  mmio_pkg::cu_return_t        cu_return_done_q;
  logic [mmio_pkg::data_w-1:0] report_errors_q;
  logic [mmio_pkg::data_w-1:0] afu_status_q;
  logic [mmio_pkg::data_w-1:0] cu_status_q;
  mmio_pkg::mmio_cmd_t         cmd_q;
  logic [mmio_pkg::data_w-1:0] cfg_data;
  logic [mmio_pkg::data_w-1:0] data_out;
  logic                        ack_q;
  mmio_pkg::mmio_resp_t        resp_q;

  // Status words from the compute unit
  always_ff @(posedge clock) begin
    cu_return_q      <= cu_return;
    cu_return_done_q <= cu_return_done;
    report_errors_q  <= report_errors;
    afu_status_q     <= afu_status;
    cu_status_q      <= cu_status;
  end

  // Line up with the descriptor lookup
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cmd_q <= '0;
    end else begin
      cmd_q <= cmd;
    end
  end

  // Word reads repeat the half chosen by address bit 0
  always_comb begin
    if (cmd_q.doubleword) begin
      cfg_data = desc_data;
    end else if (cmd_q.address[0]) begin
      cfg_data = {desc_data[31:0], desc_data[31:0]};
    end else begin
      cfg_data = {desc_data[63:32], desc_data[63:32]};
    end
  end

  //////////////////////////////////////////////////
  // Read data select
  //////////////////////////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      data_out <= '0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= (cmd_q.op != mmio_pkg::op_none);
      if (cmd_q.op == mmio_pkg::op_cfg_read) begin
        data_out <= cfg_data;
      end else if (cmd_q.op == mmio_pkg::op_mmio_read) begin
        // Unmapped addresses keep the last data
        case (cmd_q.address)
          mmio_pkg::reg_cu_return_0:      data_out <= cu_return_q.var1;
          mmio_pkg::reg_cu_return_1:      data_out <= cu_return_q.var2;
          mmio_pkg::reg_cu_return_done_0: data_out <= cu_return_done_q.var1;
          mmio_pkg::reg_cu_return_done_1: data_out <= cu_return_done_q.var2;
          mmio_pkg::reg_error_reg:        data_out <= report_errors_q;
          mmio_pkg::reg_afu_status:       data_out <= afu_status_q;
          mmio_pkg::reg_cu_status:        data_out <= cu_status_q;
          default: ;
        endcase
      end
    end
  end

  // Parity over the held data ahead of the output register
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      resp_q   <= '0;
      mmio_out <= '0;
    end else begin
      resp_q.ack         <= ack_q;
      resp_q.data        <= data_out;
      resp_q.data_parity <= mmio_pkg::odd_parity(data_out);
      mmio_out           <= resp_q;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mmio_parity_check.sv ====
`timescale 1ns/1ns
`default_nettype none

module mmio_parity_check (
  input  wire                     clock,
  input  wire                     rstn,
  input  mmio_pkg::mmio_cmd_t     cmd,
  output mmio_pkg::mmio_errors_t  mmio_errors
);

  localparam int pad_w = mmio_pkg::data_w - mmio_pkg::addr_w;

  logic                   addr_par;
  logic                   data_par;
  mmio_pkg::mmio_errors_t err_s1;
  mmio_pkg::mmio_errors_t err_s2;
  mmio_pkg::mmio_errors_t err_s3;

  // Zero padding leaves the parity unchanged
  assign addr_par = mmio_pkg::odd_parity({{pad_w{1'b0}}, cmd.address});
  assign data_par = mmio_pkg::odd_parity(cmd.data);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      err_s1 <= '0;
    end else if (cmd.op != mmio_pkg::op_none) begin
      err_s1.data_error    <= data_par ^ cmd.data_parity;
      err_s1.address_error <= addr_par ^ cmd.address_parity;
    end else begin
      err_s1 <= '0;
    end
  end

  // Delay to match the response
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      err_s2      <= '0;
      err_s3      <= '0;
      mmio_errors <= '0;
    end else begin
      err_s2      <= err_s1;
      err_s3      <= err_s2;
      mmio_errors <= err_s3;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mmio_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mmio_top (
  input  wire                         clock,
  input  wire                         rstn,
  input  mmio_pkg::mmio_req_t         mmio_in,
  output mmio_pkg::mmio_resp_t        mmio_out,
  input  mmio_pkg::cu_return_t        cu_return,
  input  mmio_pkg::cu_return_t        cu_return_done,
  input  wire [mmio_pkg::data_w-1:0]  report_errors,
  input  wire [mmio_pkg::data_w-1:0]  afu_status,
  input  wire [mmio_pkg::data_w-1:0]  cu_status,
  output mmio_pkg::cu_configure_t     cu_configure,
  output mmio_pkg::afu_configure_t    afu_configure,
  output logic                        cu_return_done_ack,
  output logic                        report_errors_ack,
  output mmio_pkg::mmio_errors_t      mmio_errors
);

  logic                        rstn_sync;
  mmio_pkg::mmio_cmd_t         cmd;
  logic [mmio_pkg::data_w-1:0] desc_data;

  // Reset asserts at once and releases on the clock
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      rstn_sync <= 1'b0;
    end else begin
      rstn_sync <= 1'b1;
    end
  end

  mmio_request_decode i_decode (
    .clock   (clock),
    .rstn    (rstn_sync),
    .mmio_in (mmio_in),
    .cmd     (cmd)
  );

  afu_descriptor_rom i_desc_rom (
    .clock     (clock),
    .rstn      (rstn_sync),
    .cmd       (cmd),
    .desc_data (desc_data)
  );

  mmio_write_regs i_write_regs (
    .clock              (clock),
    .rstn               (rstn_sync),
    .cmd                (cmd),
    .cu_configure       (cu_configure),
    .afu_configure      (afu_configure),
    .cu_return_done_ack (cu_return_done_ack),
    .report_errors_ack  (report_errors_ack)
  );

  mmio_read_path i_read_path (
    .clock          (clock),
    .rstn           (rstn_sync),
    .cmd            (cmd),
    .desc_data      (desc_data),
    .cu_return      (cu_return),
    .cu_return_done (cu_return_done),
    .report_errors  (report_errors),
    .afu_status     (afu_status),
    .cu_status      (cu_status),
    .mmio_out       (mmio_out)
  );

  mmio_parity_check i_parity_check (
    .clock       (clock),
    .rstn        (rstn_sync),
    .cmd         (cmd),
    .mmio_errors (mmio_errors)
  );

endmodule

`default_nettype wire

// ==== test/mmio_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mmio_tb;

  localparam int clock_half  = 50;
  localparam int rsp_latency = 6;
  localparam int cfg_latency = 5;
  localparam int depth       = 8192;
  // Requests in the cfg read, cfg write, status, ack, parity and mixed tests
  localparam int request_count  = 27 + 12 + 16 + 4 + 5 + 24;
  localparam int timeout_cycles = 40 * request_count + 100;

  logic                     clock;
  logic                     rstn;
  mmio_pkg::mmio_req_t      mmio_in;
  mmio_pkg::mmio_resp_t     mmio_out;
  mmio_pkg::cu_return_t     cu_return;
  mmio_pkg::cu_return_t     cu_return_done;
  logic [63:0]              report_errors;
  logic [63:0]              afu_status;
  logic [63:0]              cu_status;
  mmio_pkg::cu_configure_t  cu_configure;
  mmio_pkg::afu_configure_t afu_configure;
  logic                     cu_return_done_ack;
  logic                     report_errors_ack;
  mmio_pkg::mmio_errors_t   mmio_errors;

  int          cycle = 0;
  int          pending = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_start_errors = 0;
  string       test_name = "reset";
  logic [31:0] lfsr_state;
  logic [63:0] last_read;
  logic [63:0] desc_table [8];
  logic [23:0] write_map [8];
  logic [23:0] read_map [7];

  // Expected results keyed by the edge that samples the request
  logic                     exp_ack     [depth];
  logic                     exp_rd      [depth];
  logic [63:0]              exp_data    [depth];
  mmio_pkg::cu_configure_t  exp_cu_cfg  [depth];
  mmio_pkg::afu_configure_t exp_afu_cfg [depth];
  logic                     exp_cu_ack  [depth];
  logic                     exp_err_ack [depth];
  mmio_pkg::mmio_errors_t   exp_errors  [depth];

  mmio_top i_dut (
    .clock              (clock),
    .rstn               (rstn),
    .mmio_in            (mmio_in),
    .mmio_out           (mmio_out),
    .cu_return          (cu_return),
    .cu_return_done     (cu_return_done),
    .report_errors      (report_errors),
    .afu_status         (afu_status),
    .cu_status          (cu_status),
    .cu_configure       (cu_configure),
    .afu_configure      (afu_configure),
    .cu_return_done_ack (cu_return_done_ack),
    .report_errors_ack  (report_errors_ack),
    .mmio_errors        (mmio_errors)
  );

  always #clock_half clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  //////////////////////////////////////////////////
  // Random bits and reference model
  //////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rand_bits(input int count);
    logic [63:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[62:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // Counts the ones and returns the bit that makes the total odd
  function automatic logic odd_fill(input logic [63:0] value);
    int ones;
    ones = 0;
    for (int i = 0; i < 64; i++) begin
      ones = ones + int'(value[i]);
    end
    return (ones % 2) == 0;
  endfunction

  function automatic logic [63:0] cfg_read_value(input logic dw, input logic [23:0] addr);
    logic [63:0] full;
    full = (addr[23:1] < 23'd8) ? desc_table[addr[3:1]] : 64'h0;
    if (dw) begin
      return full;
    end
    // Odd word address picks the low half
    return addr[0] ? {2{full[31:0]}} : {2{full[63:32]}};
  endfunction

  function automatic logic [63:0] status_value(input logic [23:0] addr,
                                               input logic [63:0] previous);
    case (addr)
      mmio_pkg::reg_cu_return_0:      return cu_return.var1;
      mmio_pkg::reg_cu_return_1:      return cu_return.var2;
      mmio_pkg::reg_cu_return_done_0: return cu_return_done.var1;
      mmio_pkg::reg_cu_return_done_1: return cu_return_done.var2;
      mmio_pkg::reg_error_reg:        return report_errors;
      mmio_pkg::reg_afu_status:       return afu_status;
      mmio_pkg::reg_cu_status:        return cu_status;
      default:                        return previous;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Request driver
  //////////////////////////////////////////////////
  task automatic issue(input logic cfg, input logic read, input logic dw,
                       input logic [23:0] addr, input logic [63:0] data,
                       input logic bad_addr_par, input logic bad_data_par);
    int s;
    s = (cycle + 1) & (depth - 1);
    mmio_in.valid          = 1'b1;
    mmio_in.cfg            = cfg;
    mmio_in.read           = read;
    mmio_in.doubleword     = dw;
    mmio_in.address        = addr;
    mmio_in.address_parity = odd_fill({40'h0, addr}) ^ bad_addr_par;
    mmio_in.data           = data;
    mmio_in.data_parity    = odd_fill(data) ^ bad_data_par;
    exp_ack[s]                  = 1'b1;
    exp_errors[s].address_error = bad_addr_par;
    // Only writes carry data that can raise a data error
    exp_errors[s].data_error    = !read && bad_data_par;
    if (read) begin
      last_read   = cfg ? cfg_read_value(dw, addr) : status_value(addr, last_read);
      exp_rd[s]   = 1'b1;
      exp_data[s] = last_read;
    end else if (!cfg) begin
      case (addr)
        mmio_pkg::reg_cu_configure_0:     exp_cu_cfg[s].var1  = data;
        mmio_pkg::reg_cu_configure_1:     exp_cu_cfg[s].var2  = data;
        mmio_pkg::reg_cu_configure_2:     exp_cu_cfg[s].var3  = data;
        mmio_pkg::reg_cu_configure_3:     exp_cu_cfg[s].var4  = data;
        mmio_pkg::reg_afu_configure_0:    exp_afu_cfg[s].var1 = data;
        mmio_pkg::reg_afu_configure_1:    exp_afu_cfg[s].var2 = data;
        mmio_pkg::reg_cu_return_done_ack: exp_cu_ack[s]       = |data;
        mmio_pkg::reg_error_reg_ack:      exp_err_ack[s]      = |data;
        default: ;
      endcase
    end
    pending++;
    @(posedge clock);
    #1;
    mmio_in = '0;
  endtask

  task automatic wait_idle();
    while (pending > 0) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic load_status();
    cu_return      = {rand_bits(64), rand_bits(64)};
    cu_return_done = {rand_bits(64), rand_bits(64)};
    report_errors  = rand_bits(64);
    afu_status     = rand_bits(64);
    cu_status      = rand_bits(64);
    // Inputs settle through the status latch
    repeat (3) @(posedge clock);
    #1;
  endtask

  task automatic report_mismatch(input string what, input logic [255:0] expected,
                                 input logic [255:0] actual);
    errors++;
    $display("ERROR %s %s expected %0h actual %0h at cycle %0d",
             test_name, what, expected, actual, cycle);
  endtask

  task automatic begin_test(input string name);
    test_name         = name;
    test_start_errors = errors;
  endtask

  task automatic end_test();
    wait_idle();
    tests_run++;
    if (errors == test_start_errors) begin
      $display("test %s done, no errors", test_name);
    end else begin
      tests_failed++;
      $display("test %s done, %0d errors", test_name, errors - test_start_errors);
    end
  endtask

  //////////////////////////////////////////////////
  // Output checks on the falling edge
  //////////////////////////////////////////////////
  always @(negedge clock) begin
    int r;
    int w;
    r = (cycle - rsp_latency) & (depth - 1);
    w = (cycle - cfg_latency) & (depth - 1);
    assert (mmio_out.ack == exp_ack[r])
      else report_mismatch("ack", 256'(exp_ack[r]), 256'(mmio_out.ack));
    if (exp_rd[r]) begin
      assert (mmio_out.data == exp_data[r])
        else report_mismatch("read data", 256'(exp_data[r]), 256'(mmio_out.data));
      assert (mmio_out.data_parity == odd_fill(mmio_out.data))
        else report_mismatch("read parity", 256'(odd_fill(mmio_out.data)),
                             256'(mmio_out.data_parity));
      checks += 2;
    end
    assert (cu_configure == exp_cu_cfg[w])
      else report_mismatch("cu_configure", 256'(exp_cu_cfg[w]), 256'(cu_configure));
    assert (afu_configure == exp_afu_cfg[w])
      else report_mismatch("afu_configure", 256'(exp_afu_cfg[w]), 256'(afu_configure));
    assert (cu_return_done_ack == exp_cu_ack[r])
      else report_mismatch("cu_return_done_ack", 256'(exp_cu_ack[r]),
                           256'(cu_return_done_ack));
    assert (report_errors_ack == exp_err_ack[r])
      else report_mismatch("report_errors_ack", 256'(exp_err_ack[r]),
                           256'(report_errors_ack));
    assert (mmio_errors == exp_errors[r])
      else report_mismatch("mmio_errors", 256'(exp_errors[r]), 256'(mmio_errors));
    checks += 6;
    if (exp_ack[r]) begin
      pending--;
    end
    exp_ack[r]     = 1'b0;
    exp_rd[r]      = 1'b0;
    exp_data[r]    = '0;
    exp_cu_ack[r]  = 1'b0;
    exp_err_ack[r] = 1'b0;
    exp_errors[r]  = '0;
    exp_cu_cfg[w]  = '0;
    exp_afu_cfg[w] = '0;
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  task automatic read_descriptor();
    begin_test("cfg_read");
    // Index 8 lies past the descriptor
    for (int i = 0; i < 9; i++) begin
      issue(1'b1, 1'b1, 1'b1, 24'(2 * i), 64'h0, 1'b0, 1'b0);
      issue(1'b1, 1'b1, 1'b0, 24'(2 * i), 64'h0, 1'b0, 1'b0);
      issue(1'b1, 1'b1, 1'b0, 24'(2 * i + 1), 64'h0, 1'b0, 1'b0);
    end
    end_test();
  endtask

  task automatic pulse_config_words();
    begin_test("cfg_pulse");
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < 6; i++) begin
        issue(1'b0, 1'b0, 1'b1, write_map[i], rand_bits(64), 1'b0, 1'b0);
      end
    end
    end_test();
  endtask

  task automatic read_status_words();
    begin_test("status_read");
    for (int round = 0; round < 2; round++) begin
      wait_idle();
      load_status();
      for (int i = 0; i < 7; i++) begin
        issue(1'b0, 1'b1, 1'b1, read_map[i], 64'h0, 1'b0, 1'b0);
      end
      // Unmapped address repeats the last word
      issue(1'b0, 1'b1, 1'b1, 24'h00_00f8, 64'h0, 1'b0, 1'b0);
    end
    end_test();
  endtask

  task automatic pulse_acks();
    begin_test("ack_pulse");
    issue(1'b0, 1'b0, 1'b1, mmio_pkg::reg_cu_return_done_ack, rand_bits(64) | 64'h1, 1'b0, 1'b0);
    issue(1'b0, 1'b0, 1'b1, mmio_pkg::reg_cu_return_done_ack, 64'h0, 1'b0, 1'b0);
    issue(1'b0, 1'b0, 1'b1, mmio_pkg::reg_error_reg_ack, rand_bits(64) | 64'h1, 1'b0, 1'b0);
    issue(1'b0, 1'b0, 1'b1, mmio_pkg::reg_error_reg_ack, 64'h0, 1'b0, 1'b0);
    end_test();
  endtask

  task automatic flip_parity_bits();
    begin_test("parity");
    issue(1'b0, 1'b1, 1'b1, mmio_pkg::reg_afu_status, 64'h0, 1'b1, 1'b0);
    issue(1'b0, 1'b1, 1'b1, mmio_pkg::reg_cu_status, rand_bits(64), 1'b0, 1'b1);
    issue(1'b0, 1'b0, 1'b1, mmio_pkg::reg_cu_configure_2, rand_bits(64), 1'b0, 1'b1);
    issue(1'b0, 1'b0, 1'b1, 24'h00_0100, rand_bits(64), 1'b1, 1'b1);
    issue(1'b1, 1'b0, 1'b1, 24'h00_0004, rand_bits(64), 1'b0, 1'b1);
    end_test();
  endtask

  task automatic mix_requests();
    logic [1:0]  kind;
    logic [2:0]  pick;
    logic [23:0] addr;
    logic        dw;
    logic        bad;
    begin_test("mixed");
    for (int i = 0; i < 24; i++) begin
      kind = 2'(rand_bits(2));
      pick = 3'(rand_bits(3));
      dw   = 1'(rand_bits(1));
      bad  = (rand_bits(3) == 64'h0);
      case (kind)
        2'd0: begin
          addr = {20'h0, pick, 1'(rand_bits(1))};
          issue(1'b1, 1'b1, dw, addr, 64'h0, bad, 1'b0);
        end
        2'd1: begin
          addr = (pick == 3'd7) ? 24'h00_00f8 : read_map[pick];
          issue(1'b0, 1'b1, 1'b1, addr, 64'h0, bad, 1'b0);
        end
        2'd2: issue(1'b0, 1'b0, 1'b1, write_map[pick], rand_bits(64), bad, dw);
        // Config writes to mapped addresses must leave every output quiet
        default: issue(1'b1, 1'b0, 1'b1, write_map[pick], rand_bits(64), bad, 1'b0);
      endcase
    end
    end_test();
  endtask

  initial begin
    clock      = 1'b0;
    rstn       = 1'b0;
    mmio_in    = '0;
    lfsr_state = 32'h64ea6495;
    last_read  = '0;
    cu_return      = '0;
    cu_return_done = '0;
    report_errors  = '0;
    afu_status     = '0;
    cu_status      = '0;
    desc_table = '{mmio_pkg::desc_dw_0, mmio_pkg::desc_dw_1, mmio_pkg::desc_dw_2,
                   mmio_pkg::desc_dw_3, mmio_pkg::desc_dw_4, mmio_pkg::desc_dw_5,
                   mmio_pkg::desc_dw_6, mmio_pkg::desc_dw_7};
    write_map = '{mmio_pkg::reg_cu_configure_0, mmio_pkg::reg_cu_configure_1,
                  mmio_pkg::reg_cu_configure_2, mmio_pkg::reg_cu_configure_3,
                  mmio_pkg::reg_afu_configure_0, mmio_pkg::reg_afu_configure_1,
                  mmio_pkg::reg_cu_return_done_ack, mmio_pkg::reg_error_reg_ack};
    read_map = '{mmio_pkg::reg_cu_return_0, mmio_pkg::reg_cu_return_1,
                 mmio_pkg::reg_cu_return_done_0, mmio_pkg::reg_cu_return_done_1,
                 mmio_pkg::reg_error_reg, mmio_pkg::reg_afu_status, mmio_pkg::reg_cu_status};
    for (int i = 0; i < depth; i++) begin
      exp_ack[i]     = 1'b0;
      exp_rd[i]      = 1'b0;
      exp_data[i]    = '0;
      exp_cu_cfg[i]  = '0;
      exp_afu_cfg[i] = '0;
      exp_cu_ack[i]  = 1'b0;
      exp_err_ack[i] = 1'b0;
      exp_errors[i]  = '0;
    end
    repeat (5) @(posedge clock);
    #1;
    rstn = 1'b1;
    // One edge for the reset synchronizer and one to settle
    repeat (2) @(posedge clock);
    #1;
    read_descriptor();
    pulse_config_words();
    read_status_words();
    pulse_acks();
    flip_parity_bits();
    mix_requests();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    wait (cycle >= timeout_cycles);
    $display("Run stopped after %0d cycles with %0d requests still open", cycle, pending);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/mmio_pkg.sv
verilog/mmio_request_decode.sv
verilog/afu_descriptor_rom.sv
verilog/mmio_write_regs.sv
verilog/mmio_read_path.sv
verilog/mmio_parity_check.sv
verilog/mmio_top.sv
test/mmio_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the MMIO register block testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert -Wno-fatal --top-module mmio_tb -f compile.f -o mmio_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/mmio_sim > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log
grep -qx "PASS: all tests" sim.log && exit 0 || exit 1
